/* src/inst_pkg.sv */
package inst_pkg;

    // major opcodes of the RV32I base set
    typedef enum logic [6:0] {
        LUI      = 7'b0110111,
        AUIPC    = 7'b0010111,
        JAL      = 7'b1101111,
        JALR     = 7'b1100111,
        BRANCH   = 7'b1100011,
        LOAD     = 7'b0000011,
        STORE    = 7'b0100011,
        OP_IMM   = 7'b0010011,
        OP       = 7'b0110011,
        SYSTEM   = 7'b1110011,
        MISC_MEM = 7'b0001111
    } opcode_e;

    typedef enum logic [1:0] {
        DIRECT    = 2'd0,
        INDIRECT  = 2'd1,
        CONDITION = 2'd2
    } br_type_e;

    typedef enum logic [1:0] {
        NONE     = 2'd0,
        POP      = 2'd1,
        PUSH     = 2'd2,
        POP_PUSH = 2'd3
    } ras_type_e;

    typedef enum logic [2:0] {
        ALU,
        LOAD_C,
        STORE_C,
        BRANCH_C,
        JUMP_C,
        SYSTEM_C,
        ILLEGAL_C
    } inst_class_e;

    typedef struct packed {
        logic        branch;   // jal, jalr or conditional branch
        logic        direct;   // jal only
        br_type_e    br_type;
        ras_type_e   ras_type;
        logic [31:0] target;   // pc plus the J-immediate
    } pd_bundle_t;

endpackage

/* src/frontend_pkg.sv */
package frontend_pkg;

    localparam int block_inst_size = 8;
    localparam int block_idx_width = 3;
    localparam int vaddr_size      = 32;
    localparam int fsq_idx_width   = 4;
    localparam int ibuf_depth      = 16;
    localparam int ibuf_ptr_width  = 4;
    localparam int issue_width     = 2;

    typedef struct packed {
        logic [vaddr_size-1:0]      start_addr;
        logic [block_idx_width-1:0] size;       // slot index of the block tail
        logic                       taken;
        logic [vaddr_size-1:0]      target;
        inst_pkg::br_type_e         br_type;
        inst_pkg::ras_type_e        ras_type;
    } fetch_stream_t;

    typedef struct packed {
        fetch_stream_t                     stream;
        logic [fsq_idx_width-1:0]          fsq_idx;
        logic                              fault;
        logic [block_inst_size-1:0] [31:0] words;
    } fetch_block_t;

    typedef struct packed {
        logic                     valid;
        logic [fsq_idx_width-1:0] fsq_idx;
        fetch_stream_t            stream;   // corrected prediction
        logic                     direct;
    } pd_redirect_t;

    typedef struct packed {
        logic [31:0]              inst;
        logic [vaddr_size-1:0]    pc;
        logic [fsq_idx_width-1:0] fsq_idx;
        logic                     fault;
    } ibuf_entry_t;

    typedef struct packed {
        logic                     valid;
        logic [31:0]              inst;
        logic [vaddr_size-1:0]    pc;
        logic [fsq_idx_width-1:0] fsq_idx;
        logic                     fault;
        inst_pkg::inst_class_e    cls;
    } issue_slot_t;

endpackage

/* src/inst_predecoder.sv */
`timescale 1ns/1ps

module inst_predecoder (
    input  logic [31:0]          inst,
    input  logic [31:0]          pc,
    output inst_pkg::pd_bundle_t bundle
);
    inst_pkg::opcode_e op;
    logic              is_jal;
    logic              is_jalr;
    logic              is_cond;
    logic              link_rd;
    logic              link_rs1;
    logic [31:0]       j_imm;

    assign op       = inst_pkg::opcode_e'(inst[6:0]);
    assign is_jal   = op == inst_pkg::JAL;
    assign is_jalr  = op == inst_pkg::JALR;
    assign is_cond  = op == inst_pkg::BRANCH;
    assign link_rd  = inst[11:7] == 5'd1 || inst[11:7] == 5'd5;    // x1 or x5
    assign link_rs1 = inst[19:15] == 5'd1 || inst[19:15] == 5'd5;
    assign j_imm    = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        bundle.branch = is_jal | is_jalr | is_cond;
        bundle.direct = is_jal;
        bundle.target = pc + j_imm;
        if (is_jal)
            bundle.br_type = inst_pkg::DIRECT;
        else if (is_jalr)
            bundle.br_type = inst_pkg::INDIRECT;
        else
            bundle.br_type = inst_pkg::CONDITION;

        // a call links through rd, a return reads the link through rs1
        if (is_jal)
            bundle.ras_type = link_rd ? inst_pkg::PUSH : inst_pkg::NONE;
        else if (is_jalr)
            bundle.ras_type = inst_pkg::ras_type_e'({link_rd, link_rs1});
        else
            bundle.ras_type = inst_pkg::NONE;
    end

endmodule

/* src/predecode.sv */
`timescale 1ns/1ps

module predecode (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        fetch_en,
    input  frontend_pkg::fetch_block_t  fetch_block,
    input  logic                        flush,
    input  logic                        ibuf_full,
    output frontend_pkg::pd_redirect_t  pd_redirect,
    output logic [frontend_pkg::block_idx_width:0] wr_num,
    output frontend_pkg::ibuf_entry_t [frontend_pkg::block_inst_size-1:0] wr_entries
);
    typedef logic [frontend_pkg::block_idx_width-1:0] idx_t;
    typedef logic [frontend_pkg::vaddr_size-1:0]      vaddr_t;

    inst_pkg::pd_bundle_t [frontend_pkg::block_inst_size-1:0] in_bundles;
    inst_pkg::pd_bundle_t [frontend_pkg::block_inst_size-1:0] stage_bundles;
    frontend_pkg::fetch_block_t stage_block;
    logic                       stage_valid;
    logic                       accept;
    logic [frontend_pkg::block_inst_size-1:0] jal_hit;
    logic [frontend_pkg::block_inst_size-1:0] wr_mask;
    logic                       has_jal;
    idx_t                       jal_idx;
    idx_t                       keep_idx;
    logic                       jal_redirect;
    logic                       fall_redirect;
    vaddr_t                     fall_target;

    for (genvar i = 0; i < frontend_pkg::block_inst_size; i++) begin : g_pd
        inst_predecoder pd_i (
            .inst   (fetch_block.words[i]),
            .pc     (fetch_block.stream.start_addr + (vaddr_t'(i) << 2)),
            .bundle (in_bundles[i])
        );
        assign jal_hit[i] = stage_valid && idx_t'(i) <= stage_block.stream.size
                            && stage_bundles[i].direct;
        assign wr_mask[i] = stage_valid && !ibuf_full && idx_t'(i) <= keep_idx;
    end

    assign accept = fetch_en & ~ibuf_full & ~pd_redirect.valid & ~flush;

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            stage_valid <= 1'b0;
        else if (flush)
            stage_valid <= 1'b0;
        else if (!ibuf_full)
            stage_valid <= accept;   // a redirect blocks accept and so empties the stage
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            stage_block   <= fetch_block;
            stage_bundles <= in_bundles;
        end
    end

    // lowest live jal wins
    always_comb begin
        has_jal = 1'b0;
        jal_idx = '0;
        for (int i = frontend_pkg::block_inst_size - 1; i >= 0; i--) begin
            if (jal_hit[i]) begin
                has_jal = 1'b1;
                jal_idx = idx_t'(i);
            end
        end
    end

    assign jal_redirect = has_jal && (!stage_block.stream.taken
                          || stage_block.stream.size != jal_idx
                          || stage_block.stream.br_type != inst_pkg::DIRECT
                          || stage_block.stream.target != stage_bundles[jal_idx].target);
    assign fall_redirect = stage_valid && !has_jal && stage_block.stream.taken
                           && !stage_bundles[stage_block.stream.size].branch;
    assign fall_target = stage_block.stream.start_addr
                         + (vaddr_t'(stage_block.stream.size) << 2) + vaddr_t'(4);
    assign keep_idx = has_jal ? jal_idx : stage_block.stream.size;

    always_comb begin
        pd_redirect.valid             = (jal_redirect | fall_redirect) & ~ibuf_full;
        pd_redirect.fsq_idx           = stage_block.fsq_idx;
        pd_redirect.direct            = has_jal;
        pd_redirect.stream.start_addr = stage_block.stream.start_addr;
        pd_redirect.stream.size       = keep_idx;
        pd_redirect.stream.taken      = has_jal;
        pd_redirect.stream.target     = has_jal ? stage_bundles[jal_idx].target : fall_target;
        pd_redirect.stream.br_type    = has_jal ? stage_bundles[jal_idx].br_type
                                                : stage_block.stream.br_type;
        pd_redirect.stream.ras_type   = has_jal ? stage_bundles[jal_idx].ras_type
                                                : inst_pkg::NONE;
    end

    // pack the enabled slots down to the low end of the write port
    always_comb begin
        logic [frontend_pkg::block_idx_width:0] n;
        n = '0;
        wr_entries = '0;
        for (int i = 0; i < frontend_pkg::block_inst_size; i++) begin
            if (wr_mask[i]) begin
                wr_entries[n].inst    = stage_block.words[i];
                wr_entries[n].pc      = stage_block.stream.start_addr + (vaddr_t'(i) << 2);
                wr_entries[n].fsq_idx = stage_block.fsq_idx;
                wr_entries[n].fault   = stage_block.fault;
                n = n + 1'b1;
            end
        end
        wr_num = n;
    end

endmodule

/* src/inst_buffer.sv */
`timescale 1ns/1ps

module inst_buffer (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   flush,
    input  logic [frontend_pkg::block_idx_width:0] wr_num,
    input  frontend_pkg::ibuf_entry_t [frontend_pkg::block_inst_size-1:0] wr_entries,
    input  logic [1:0]                             pop_num,
    output frontend_pkg::ibuf_entry_t [frontend_pkg::issue_width-1:0] head_entries,
    output logic [frontend_pkg::ibuf_ptr_width:0]  count,
    output logic                                   ibuf_full
);
    typedef logic [frontend_pkg::ibuf_ptr_width-1:0] ptr_t;
    typedef logic [frontend_pkg::ibuf_ptr_width:0]   cnt_t;

    frontend_pkg::ibuf_entry_t mem [frontend_pkg::ibuf_depth];
    ptr_t head;
    ptr_t tail;

    // pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            head  <= head + ptr_t'(pop_num);
            tail  <= tail + ptr_t'(wr_num);
            count <= count + cnt_t'(wr_num) - cnt_t'(pop_num);
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < frontend_pkg::block_inst_size; i++) begin
            if (i < int'(wr_num))
                mem[tail + ptr_t'(i)] <= wr_entries[i];
        end
    end

    for (genvar k = 0; k < frontend_pkg::issue_width; k++) begin : g_head
        assign head_entries[k] = mem[head + ptr_t'(k)];
    end

    // full once a whole block would no longer fit
    assign ibuf_full = (cnt_t'(frontend_pkg::ibuf_depth) - count)
                       < cnt_t'(frontend_pkg::block_inst_size);

endmodule

/* src/inst_issue.sv */
`timescale 1ns/1ps

module inst_issue (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  flush,
    input  logic                                  issue_stall,
    input  frontend_pkg::ibuf_entry_t [frontend_pkg::issue_width-1:0] head_entries,
    input  logic [frontend_pkg::ibuf_ptr_width:0] count,
    output logic [1:0]                            pop_num,
    output frontend_pkg::issue_slot_t [frontend_pkg::issue_width-1:0] issue_slots
);
    logic [frontend_pkg::issue_width-1:0] slot_valid;
    frontend_pkg::ibuf_entry_t [frontend_pkg::issue_width-1:0] slot_entry;
    inst_pkg::inst_class_e slot_cls [frontend_pkg::issue_width];

    function automatic inst_pkg::inst_class_e classify(input logic [31:0] inst);
        inst_pkg::inst_class_e cls;
        case (inst[6:0])
            inst_pkg::LUI, inst_pkg::AUIPC,
            inst_pkg::OP_IMM, inst_pkg::OP:   cls = inst_pkg::ALU;
            inst_pkg::LOAD:                   cls = inst_pkg::LOAD_C;
            inst_pkg::STORE:                  cls = inst_pkg::STORE_C;
            inst_pkg::BRANCH:                 cls = inst_pkg::BRANCH_C;
            inst_pkg::JAL, inst_pkg::JALR:    cls = inst_pkg::JUMP_C;
            inst_pkg::SYSTEM, inst_pkg::MISC_MEM: cls = inst_pkg::SYSTEM_C;
            default:                          cls = inst_pkg::ILLEGAL_C;
        endcase
        return cls;
    endfunction

    assign pop_num = issue_stall ? 2'd0 : (count >= 2 ? 2'd2 : count[1:0]);

    // slot k is valid only if k entries before it went out too
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            slot_valid <= '0;
        else if (flush)
            slot_valid <= '0;
        else
            for (int k = 0; k < frontend_pkg::issue_width; k++)
                slot_valid[k] <= k < int'(pop_num);
    end

    always_ff @(posedge clk) begin
        for (int k = 0; k < frontend_pkg::issue_width; k++) begin
            slot_entry[k] <= head_entries[k];
            slot_cls[k]   <= classify(head_entries[k].inst);
        end
    end

    always_comb begin
        for (int k = 0; k < frontend_pkg::issue_width; k++) begin
            issue_slots[k].valid   = slot_valid[k];
            issue_slots[k].inst    = slot_entry[k].inst;
            issue_slots[k].pc      = slot_entry[k].pc;
            issue_slots[k].fsq_idx = slot_entry[k].fsq_idx;
            issue_slots[k].fault   = slot_entry[k].fault;
            issue_slots[k].cls     = slot_cls[k];
        end
    end

endmodule

/* src/frontend_top.sv */
`timescale 1ns/1ps

module frontend_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       fetch_en,
    input  frontend_pkg::fetch_block_t fetch_block,
    input  logic                       flush,
    input  logic                       issue_stall,
    output logic                       ibuf_full,
    output frontend_pkg::pd_redirect_t pd_redirect,
    output frontend_pkg::issue_slot_t [frontend_pkg::issue_width-1:0] issue_slots
);
    logic [frontend_pkg::block_idx_width:0] wr_num;
    frontend_pkg::ibuf_entry_t [frontend_pkg::block_inst_size-1:0] wr_entries;
    frontend_pkg::ibuf_entry_t [frontend_pkg::issue_width-1:0]     head_entries;
    logic [frontend_pkg::ibuf_ptr_width:0] count;
    logic [1:0]                            pop_num;

    predecode predecode_i (
        .clk, .rst, .fetch_en, .fetch_block, .flush, .ibuf_full,
        .pd_redirect, .wr_num, .wr_entries
    );

    inst_buffer inst_buffer_i (
        .clk, .rst, .flush, .wr_num, .wr_entries, .pop_num,
        .head_entries, .count, .ibuf_full
    );

    inst_issue inst_issue_i (
        .clk, .rst, .flush, .issue_stall, .head_entries, .count,
        .pop_num, .issue_slots
    );

endmodule

/* bench/frontend_asserts.sv */
`timescale 1ns/1ps

module frontend_asserts (
    input logic                                   clk,
    input logic                                   rst,
    input logic [frontend_pkg::block_idx_width:0] wr_num,
    input logic [1:0]                             pop_num,
    input logic [frontend_pkg::ibuf_ptr_width:0]  count,
    input logic                                   ibuf_full
);

    count_in_depth: assert property (@(posedge clk) disable iff (rst)
        count <= 5'(frontend_pkg::ibuf_depth))
        else $error("buffer count %0d is above the depth", count);

    // a full buffer must hold the predecode stage back
    no_write_when_full: assert property (@(posedge clk) disable iff (rst)
        wr_num != '0 |-> !ibuf_full)
        else $error("write of %0d entries while the buffer is full", wr_num);

    pop_within_count: assert property (@(posedge clk) disable iff (rst)
        5'(pop_num) <= count)
        else $error("pop of %0d entries with only %0d stored", pop_num, count);

endmodule

/* bench/frontend_checker.sv */
`timescale 1ns/1ps

module frontend_checker (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       fetch_en,
    input  logic                       flush,
    input  logic                       issue_stall,
    input  logic                       ibuf_full,
    input  frontend_pkg::fetch_block_t fetch_block,
    input  frontend_pkg::pd_redirect_t pd_redirect,
    input  frontend_pkg::issue_slot_t [frontend_pkg::issue_width-1:0] issue_slots,
    input  frontend_pkg::pd_redirect_t exp_redirect,   // expected for the block on fetch_block
    input  int                         case_id,
    output logic                       idle,
    output int                         pass_cnt,
    output int                         fail_cnt,
    output int                         loose_errs
);
    frontend_pkg::issue_slot_t  exp_q [$];
    int                         id_q [$];
    int                         remaining [64];    // entries still due, plus one for the stage
    int                         errs [64];
    logic                       stage_pend;
    int                         stage_id;
    int                         stage_n;           // entries the stage block writes
    frontend_pkg::pd_redirect_t stage_exp;
    int                         occ;               // buffer occupancy in the current cycle
    int                         exp_pops;          // issue slots due valid in the current cycle
    logic                       flush_pend;
    int                         flush_id;

    function automatic inst_pkg::inst_class_e class_of(input logic [31:0] inst);
        inst_pkg::inst_class_e cls;
        case (inst[6:0])
            7'h37, 7'h17, 7'h13, 7'h33: cls = inst_pkg::ALU;
            7'h03:                      cls = inst_pkg::LOAD_C;
            7'h23:                      cls = inst_pkg::STORE_C;
            7'h63:                      cls = inst_pkg::BRANCH_C;
            7'h6f, 7'h67:               cls = inst_pkg::JUMP_C;
            7'h73, 7'h0f:               cls = inst_pkg::SYSTEM_C;
            default:                    cls = inst_pkg::ILLEGAL_C;
        endcase
        return cls;
    endfunction

    task automatic compare_field(input int id, input string name,
                                 input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("MISMATCH test %0d %s: expected %h, actual %h", id, name, exp, act);
            errs[id]++;
        end
    endtask

    // levels that belong to no open test count as other errors
    task automatic check_level(input int id, input string name,
                               input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
            if (id >= 0)
                errs[id]++;
            else
                loose_errs++;
        end
    endtask

    task automatic finish_test(input int id);
        if (errs[id] == 0) begin
            pass_cnt++;
            $display("test %0d: ok", id);
        end else begin
            fail_cnt++;
            $display("test %0d: failed with %0d errors", id, errs[id]);
        end
    endtask

    task automatic retire(input int id);
        remaining[id]--;
        if (remaining[id] == 0)
            finish_test(id);
    endtask

    always @(posedge clk or posedge rst) begin
        frontend_pkg::issue_slot_t e;
        int   id;
        int   keep;
        int   lvl_id;
        int   writes;
        int   pops;
        logic exp_full;
        logic exp_redir;
        if (rst) begin
            exp_q.delete();
            id_q.delete();
            stage_pend = 1'b0;
            stage_id = 0;
            stage_n = 0;
            occ = 0;
            exp_pops = 0;
            flush_pend = 1'b0;
            flush_id = 0;
            pass_cnt = 0;
            fail_cnt = 0;
            loose_errs = 0;
        end else begin
            // the first cycle after a flush belongs to the flush test
            lvl_id = flush_pend ? flush_id : -1;
            exp_full = (frontend_pkg::ibuf_depth - occ) < frontend_pkg::block_inst_size;
            exp_redir = stage_pend && stage_exp.valid && !exp_full;
            check_level(lvl_id, "ibuf_full", 32'(exp_full), 32'(ibuf_full));
            for (int k = 0; k < frontend_pkg::issue_width; k++)
                check_level(lvl_id, $sformatf("issue_slots[%0d].valid", k),
                            32'(k < exp_pops), 32'(issue_slots[k].valid));
            if (flush_pend) begin
                flush_pend = 1'b0;
                finish_test(flush_id);
            end
            writes = (stage_pend && !exp_full && !flush) ? stage_n : 0;
            pops = issue_stall ? 0 : (occ < 2 ? occ : 2);

            for (int k = 0; k < frontend_pkg::issue_width; k++) begin
                if (issue_slots[k].valid && exp_q.size() == 0) begin
                    $display("issue slot %0d carried pc %h with nothing expected", k,
                             issue_slots[k].pc);
                    loose_errs++;
                end else if (issue_slots[k].valid) begin
                    e = exp_q.pop_front();
                    id = id_q.pop_front();
                    compare_field(id, "issue_slots.inst", e.inst, issue_slots[k].inst);
                    compare_field(id, "issue_slots.pc", e.pc, issue_slots[k].pc);
                    compare_field(id, "issue_slots.fsq_idx", 32'(e.fsq_idx),
                                  32'(issue_slots[k].fsq_idx));
                    compare_field(id, "issue_slots.fault", 32'(e.fault),
                                  32'(issue_slots[k].fault));
                    compare_field(id, "issue_slots.cls", 32'(e.cls), 32'(issue_slots[k].cls));
                    retire(id);
                end
            end

            // redirect is only visible while the buffer has room
            if (stage_pend && !exp_full) begin
                compare_field(stage_id, "pd_redirect.valid", 32'(stage_exp.valid),
                              32'(pd_redirect.valid));
                if (stage_exp.valid && pd_redirect.valid) begin
                    compare_field(stage_id, "pd_redirect.size", 32'(stage_exp.stream.size),
                                  32'(pd_redirect.stream.size));
                    compare_field(stage_id, "pd_redirect.taken", 32'(stage_exp.stream.taken),
                                  32'(pd_redirect.stream.taken));
                    compare_field(stage_id, "pd_redirect.target", stage_exp.stream.target,
                                  pd_redirect.stream.target);
                    compare_field(stage_id, "pd_redirect.direct", 32'(stage_exp.direct),
                                  32'(pd_redirect.direct));
                    compare_field(stage_id, "pd_redirect.ras_type", 32'(stage_exp.stream.ras_type),
                                  32'(pd_redirect.stream.ras_type));
                    compare_field(stage_id, "pd_redirect.fsq_idx", 32'(stage_exp.fsq_idx),
                                  32'(pd_redirect.fsq_idx));
                    compare_field(stage_id, "pd_redirect.start_addr", stage_exp.stream.start_addr,
                                  pd_redirect.stream.start_addr);
                end
            end else if (pd_redirect.valid) begin
                $display("pd_redirect.valid is high while no redirect may be raised");
                loose_errs++;
            end
            if (stage_pend && (!exp_full || flush)) begin
                stage_pend = 1'b0;
                retire(stage_id);
            end

            if (flush) begin
                while (id_q.size() > 0) begin
                    void'(exp_q.pop_front());
                    retire(id_q.pop_front());
                end
                flush_pend = 1'b1;
                flush_id = case_id;
            end

            if (fetch_en && !exp_full && !exp_redir && !flush) begin
                keep = exp_redirect.valid ? int'(exp_redirect.stream.size)
                                          : int'(fetch_block.stream.size);
                for (int i = 0; i <= keep; i++) begin
                    e = '0;
                    e.valid   = 1'b1;
                    e.inst    = fetch_block.words[i];
                    e.pc      = fetch_block.stream.start_addr + 32'(i * 4);
                    e.fsq_idx = fetch_block.fsq_idx;
                    e.fault   = fetch_block.fault;
                    e.cls     = class_of(fetch_block.words[i]);
                    exp_q.push_back(e);
                    id_q.push_back(case_id);
                end
                remaining[case_id] = keep + 2;
                stage_pend = 1'b1;
                stage_id = case_id;
                stage_n = keep + 1;
                stage_exp = exp_redirect;
            end

            occ = flush ? 0 : occ + writes - pops;
            exp_pops = flush ? 0 : pops;
        end
        idle = !stage_pend && !flush_pend && exp_q.size() == 0;
    end

endmodule

/* bench/tb_frontend.sv */
`timescale 1ns/1ps

module tb_frontend;
    logic clk;
    logic rst;
    logic fetch_en;
    logic flush;
    logic issue_stall;
    logic ibuf_full;
    frontend_pkg::fetch_block_t fetch_block;
    frontend_pkg::pd_redirect_t pd_redirect;
    frontend_pkg::issue_slot_t [frontend_pkg::issue_width-1:0] issue_slots;
    frontend_pkg::pd_redirect_t exp_redirect;
    int   case_id;
    logic idle;
    int   pass_cnt;
    int   fail_cnt;
    int   loose_errs;

    byte                        kinds [64];
    frontend_pkg::fetch_block_t blocks [64];
    frontend_pkg::pd_redirect_t redirects [64];
    int n_cases;
    int setup_errs;
    int cycles = 0;
    int cycle_limit = 1000;

    frontend_top dut_i (.*);

    frontend_checker checker_i (.*);

    bind inst_buffer frontend_asserts asserts_i (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // about one stall cycle in four
    initial begin
        issue_stall = 1'b0;
        void'($urandom(4));
        forever begin
            @(posedge clk);
            #1;
            issue_stall = ($urandom % 4) == 0;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("run stopped after %0d cycles with tests still open", cycles);
            $display("TEST FAIL");
            $finish;
        end
    end

    task automatic read_cases();
        int          fd;
        int          n;
        string       line;
        logic [31:0] v [22];
        n_cases = 0;
        fd = $fopen("bench/frontend_cases.txt", "r");
        if (fd == 0) begin
            $display("case file bench/frontend_cases.txt could not be opened");
            setup_errs++;
        end else begin
            while ($fgets(line, fd) > 0) begin
                if (line[0] == "F") begin
                    kinds[n_cases] = "F";
                    n_cases++;
                end else if (line[0] == "B") begin
                    n = $sscanf(line,
                        "B %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10],
                        v[11], v[12], v[13], v[14], v[15], v[16], v[17], v[18], v[19],
                        v[20], v[21]);
                    if (n != 22) begin
                        $display("case line %0d has %0d fields instead of 22", n_cases, n);
                        setup_errs++;
                    end
                    kinds[n_cases] = "B";
                    blocks[n_cases].stream.start_addr = v[0];
                    blocks[n_cases].stream.size       = v[1][2:0];
                    blocks[n_cases].stream.taken      = v[2][0];
                    blocks[n_cases].stream.target     = v[3];
                    blocks[n_cases].stream.br_type    = inst_pkg::br_type_e'(v[4][1:0]);
                    blocks[n_cases].stream.ras_type   = inst_pkg::ras_type_e'(v[5][1:0]);
                    blocks[n_cases].fsq_idx           = v[6][3:0];
                    blocks[n_cases].fault             = v[7][0];
                    for (int i = 0; i < frontend_pkg::block_inst_size; i++)
                        blocks[n_cases].words[i] = v[8 + i];
                    // fsq_idx and start_addr of a redirect copy the block
                    redirects[n_cases] = '0;
                    redirects[n_cases].valid             = v[16][0];
                    redirects[n_cases].fsq_idx           = v[6][3:0];
                    redirects[n_cases].stream.start_addr = v[0];
                    redirects[n_cases].stream.size       = v[17][2:0];
                    redirects[n_cases].stream.taken      = v[18][0];
                    redirects[n_cases].stream.target     = v[19];
                    redirects[n_cases].direct            = v[20][0];
                    redirects[n_cases].stream.ras_type   = inst_pkg::ras_type_e'(v[21][1:0]);
                    n_cases++;
                end
            end
            $fclose(fd);
        end
    endtask

    // hold the block until the front end takes it
    task automatic send_block(input int c);
        logic accepted;
        fetch_block = blocks[c];
        exp_redirect = redirects[c];
        case_id = c;
        fetch_en = 1'b1;
        do begin
            @(posedge clk);
            accepted = !ibuf_full && !pd_redirect.valid;
            #1;
        end while (!accepted);
        fetch_en = 1'b0;
    endtask

    task automatic apply_flush(input int c);
        case_id = c;
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
    endtask

    initial begin
        rst = 1'b1;
        fetch_en = 1'b0;
        flush = 1'b0;
        fetch_block = '0;
        exp_redirect = '0;
        case_id = 0;
        setup_errs = 0;
        read_cases();
        cycle_limit = 40 * n_cases + 200;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int c = 0; c < n_cases; c++) begin
            if (kinds[c] == "F")
                apply_flush(c);
            else
                send_block(c);
        end
        do begin
            @(posedge clk);
            #1;
        end while (!idle);
        repeat (4) @(posedge clk);   // late or doubled entries still get caught
        #1;
        $display("%0d tests passed, %0d failed, %0d other errors", pass_cnt, fail_cnt,
                 loose_errs + setup_errs);
        if (fail_cnt == 0 && loose_errs == 0 && setup_errs == 0 && pass_cnt == n_cases)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

/* bench/frontend_cases.txt */
# B start size taken target br_type ras_type fsq fault w0..w7 exp_valid exp_size exp_taken
# exp_target exp_direct exp_ras (hex); br_type 0 direct 1 indirect 2 cond; F flushes
B 1000 7 0 0 2 0 1 0 13 2081b3 a283 50a223 13 10b7 73 0 0 0 0 0 0 0
B 2000 7 0 0 2 0 2 0 13 13 10000ef 13 13 13 13 13 1 2 1 2018 1 2
B 3000 1 1 3100 0 0 3 0 2081b3 80006f 13 13 13 13 13 13 1 1 1 300c 1 0
B 4000 3 1 4800 0 0 4 0 13 2081b3 a283 50a223 13 13 13 13 1 3 0 4010 0 0
B 5000 4 1 5020 0 2 5 0 13 13 a283 13 10000ef 13 13 13 0 0 0 0 0 0
B 6000 5 1 6100 2 0 6 0 13 13 13 13 13 208463 13 13 0 0 0 0 0 0
B 7000 2 0 0 2 0 7 0 10b7 13 13 13 13 10000ef 13 13 0 0 0 0 0 0
B 7100 3 1 0 1 1 8 0 13 13 13 8067 13 13 13 13 0 0 0 0 0 0
B 8000 7 0 0 2 0 9 0 13 2081b3 a283 50a223 10b7 73 13 13 0 0 0 0 0 0
B 8020 7 0 0 2 0 a 1 2081b3 13 13 a283 0 13 50a223 13 0 0 0 0 0 0
B 8040 7 0 0 2 0 b 0 13 13 10b7 13 2081b3 13 73 13 0 0 0 0 0 0
B 8060 7 0 0 2 0 c 0 a283 a283 13 13 13 50a223 13 2081b3 0 0 0 0 0 0
B 8080 7 0 0 2 0 d 0 13 13 13 13 13 13 13 13 0 0 0 0 0 0
F
B 9000 7 1 9000 0 0 e 0 80006f 13 13 13 13 13 13 13 1 0 1 9008 1 0
B 9100 7 0 0 2 0 f 0 10b7 2081b3 a283 50a223 208463 13 73 0 0 0 0 0 0 0

/* flist.f */
src/inst_pkg.sv
src/frontend_pkg.sv
src/inst_predecoder.sv
src/predecode.sv
src/inst_buffer.sv
src/inst_issue.sv
src/frontend_top.sv
bench/frontend_asserts.sv
bench/frontend_checker.sv
bench/tb_frontend.sv

/* run.sh */
#!/bin/sh
log=sim.log

verilator --binary --timing --assert -Wno-fatal -f flist.f \
    --top-module tb_frontend -Mdir obj_dir -o sim_frontend
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_frontend > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAIL" "$log"; then
    exit 1
fi
if ! grep -q "TEST PASS" "$log"; then
    echo "no verdict found in $log"
    exit 1
fi
exit 0
